//--- build.f
+incdir+hdl
hdl/iic_pkg.sv
hdl/iic_if.sv
hdl/iic_tick_gen.sv
hdl/iic_cmd_ctrl.sv
hdl/iic_seq.sv
hdl/iic_byte_engine.sv
hdl/iic_eeprom_ctrl.sv
tb/tb_iic_eeprom_model.sv
tb/tb_iic_eeprom_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# compile with Verilator and run; the exit status carries the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tb_iic_eeprom_ctrl \
	-Mdir obj_dir &&
./obj_dir/Vtb_iic_eeprom_ctrl ||
exit 1

//--- tb/tb_iic_eeprom_ctrl.sv
//**************************************************
// testbench for the serial EEPROM controller
// resolves the open-drain SDA between DUT and EEPROM model,
// runs directed tests and checks against a memory scoreboard
//**************************************************
`timescale 1ns/1ps

module tb_iic_eeprom_ctrl;
	localparam logic [6:0]  MODEL_ID   = 7'h50;
	localparam logic [6:0]  ABSENT_ID  = 7'h51;
	localparam logic [31:0] LFSR_SEED  = 32'h2820_9629;
	localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
	localparam int          OP_TIMEOUT = 3000;	// clk cycles per transfer
	localparam int          WP_WATCH   = 64;

	logic                 clk;
	logic                 rst_n;
	logic [1:0]           command;
	logic                 two_bytes;
	logic                 software_wp;
	iic_pkg::iic_dev_id_t dev_id;
	iic_pkg::iic_byte_t   word_addr;
	iic_pkg::iic_word_t   wr_data;
	logic                 busy;
	logic                 fail;
	iic_pkg::iic_word_t   rd_data;
	logic                 scl;
	logic                 dut_sda_low;
	logic                 model_sda_low;
	logic                 sda_bus;
	logic [7:0]           expect_mem [256];
	logic [31:0]          lfsr_state;

	assign sda_bus = !(dut_sda_low || model_sda_low);	// open-drain wire

	iic_eeprom_ctrl dut0 (
		.clk(clk), .rst_n(rst_n), .command(command), .two_bytes(two_bytes),
		.software_wp(software_wp), .dev_id(dev_id), .word_addr(word_addr),
		.wr_data(wr_data), .busy(busy), .fail(fail), .rd_data(rd_data),
		.scl(scl), .sda_drive_low(dut_sda_low), .sda_in(sda_bus)
	);

	tb_iic_eeprom_model #(.DEV_ID(MODEL_ID)) eeprom0 (
		.clk(clk), .rst_n(rst_n), .scl(scl), .sda(sda_bus), .sda_drive_low(model_sda_low)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//**************************************************
	// reporting and checking
	//**************************************************
	task automatic stop_on_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("ERR %s got 0x%0h expected 0x%0h", name, got, expected);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got == expected)
		else
			stop_on_mismatch(name, got, expected);
	endtask

	function automatic logic [7:0] initial_byte(input logic [7:0] a);
		return {a[3:0], a[7:4]} ^ 8'h96;
	endfunction

	task automatic compare_memory();
		for (int i = 0; i < 256; i++)
			check_value($sformatf("model mem[%0h]", i), 32'(eeprom0.mem[i]),
				32'(expect_mem[i]));
	endtask

	// Galois LFSR, one step per bit
	function automatic logic lfsr_step();
		logic out;
		out        = lfsr_state[0];
		lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? LFSR_TAPS : 32'h0);
		return out;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] value);
		value = 32'h0;
		for (int i = 0; i < n; i++)
			value = {value[30:0], lfsr_step()};
	endtask

	//**************************************************
	// bus operations
	//**************************************************
	task automatic pulse_command(input logic [1:0] cmd, input logic [6:0] id,
		input logic [7:0] addr, input logic [15:0] data, input logic two);
		@(posedge clk);
		command   <= cmd;
		dev_id    <= id;
		word_addr <= addr;
		wr_data   <= data;
		two_bytes <= two;
		@(posedge clk);
		command <= 2'b00;
	endtask

	task automatic run_transfer(input logic [1:0] cmd, input logic [6:0] id,
		input logic [7:0] addr, input logic [15:0] data, input logic two);
		int n;
		pulse_command(cmd, id, addr, data, two);
		@(negedge clk);
		check_value("busy", 32'(busy), 32'h1);	// accepted
		check_value("fail", 32'(fail), 32'h0);
		n = 0;
		while (busy && n < OP_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		assert (!busy)
		else
			stop_on_error("busy stayed high past the transfer timeout");
	endtask

	task automatic write_and_check(input logic [7:0] addr, input logic [15:0] data,
		input logic two);
		run_transfer(2'b10, MODEL_ID, addr, data, two);
		check_value("fail", 32'(fail), 32'h0);
		if (two)
		begin
			expect_mem[addr]        = data[15:8];	// high byte first
			expect_mem[addr + 8'd1] = data[7:0];
		end
		else
			expect_mem[addr] = data[7:0];
		compare_memory();
	endtask

	task automatic read_and_check(input logic [7:0] addr, input logic two);
		logic [15:0] expected;
		run_transfer(2'b01, MODEL_ID, addr, 16'h0000, two);
		check_value("fail", 32'(fail), 32'h0);
		expected = two ? {expect_mem[addr], expect_mem[addr + 8'd1]} : {8'h00, expect_mem[addr]};
		check_value("rd_data", 32'(rd_data), 32'(expected));
	endtask

	//**************************************************
	// directed tests
	//**************************************************
	task automatic test_reset_state();
		@(negedge clk);
		check_value("busy", 32'(busy), 32'h0);
		check_value("fail", 32'(fail), 32'h0);
		check_value("scl", 32'(scl), 32'h1);
		check_value("sda_drive_low", 32'(dut_sda_low), 32'h0);
		check_value("rd_data", 32'(rd_data), 32'h0);
	endtask

	task automatic test_write_protect();
		@(posedge clk);
		software_wp <= 1'b1;
		pulse_command(2'b10, MODEL_ID, 8'h40, 16'hbeef, 1'b1);
		@(negedge clk);
		check_value("busy", 32'(busy), 32'h0);
		@(negedge clk);
		check_value("fail", 32'(fail), 32'h1);	// two cycles after the pulse
		repeat (WP_WATCH)
		begin
			@(negedge clk);
			check_value("scl", 32'(scl), 32'h1);
			check_value("busy", 32'(busy), 32'h0);
		end
		compare_memory();
		@(posedge clk);
		software_wp <= 1'b0;
		read_and_check(8'h40, 1'b1);	// clears fail
	endtask

	task automatic test_absent_device();
		logic [15:0] held;
		run_transfer(2'b10, ABSENT_ID, 8'h10, 16'h1234, 1'b1);
		check_value("fail", 32'(fail), 32'h1);
		compare_memory();
		held = rd_data;
		run_transfer(2'b01, ABSENT_ID, 8'h10, 16'h0000, 1'b0);
		check_value("fail", 32'(fail), 32'h1);
		check_value("rd_data", 32'(rd_data), 32'(held));
		compare_memory();
	endtask

	task automatic test_random_words();
		logic [31:0] r;
		logic [7:0]  addr;
		logic [15:0] data;
		logic        two;
		for (int i = 0; i < 8; i++)
		begin
			take_bits(8, r);
			addr = r[7:0];
			take_bits(16, r);
			data = r[15:0];
			take_bits(1, r);
			two = r[0];
			write_and_check(addr, data, two);
			read_and_check(addr, two);
		end
	endtask

	initial
	begin
		lfsr_state  = LFSR_SEED;
		rst_n       = 1'b0;
		command     = 2'b00;
		two_bytes   = 1'b0;
		software_wp = 1'b0;
		dev_id      = MODEL_ID;
		word_addr   = 8'h00;
		wr_data     = 16'h0000;
		for (int a = 0; a < 256; a++)
			expect_mem[a] = initial_byte(8'(a));
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		test_reset_state();
		write_and_check(8'h23, 16'h005c, 1'b0);	// one byte
		read_and_check(8'h23, 1'b0);
		write_and_check(8'h80, 16'ha5c3, 1'b1);	// two bytes
		read_and_check(8'h80, 1'b1);
		test_write_protect();
		test_absent_device();
		test_random_words();

		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- tb/tb_iic_eeprom_model.sv
//**************************************************
// behavioral 256-byte serial EEPROM for the testbench
// oversamples SCL and the resolved SDA level on clk
// acks its device id, takes a word address, then
// stores written bytes or sends bytes from that address
//**************************************************
`timescale 1ns/1ps

module tb_iic_eeprom_model #(
	parameter logic [6:0] DEV_ID = 7'h50
) (
	input  logic clk,
	input  logic rst_n,
	input  logic scl,
	input  logic sda,		// resolved bus level
	output logic sda_drive_low
);
	typedef enum logic [2:0] {M_IDLE, M_RECV, M_ACK, M_SEND, M_MACK} model_state_e;

	logic [7:0]   mem [256];
	model_state_e state;
	logic         scl_q;
	logic         sda_q;
	logic [3:0]   bit_cnt;
	logic [7:0]   shreg;		// byte coming in
	logic [7:0]   out_byte;		// byte going out, msb first
	logic [7:0]   ptr;
	logic [1:0]   byte_n;		// 0 dev id, 1 word addr, 2 data
	logic         to_send;
	logic         mack;
	logic         start_seen;
	logic         stop_seen;
	logic         rise;
	logic         fall;

	assign start_seen = scl && scl_q && sda_q && !sda;
	assign stop_seen  = scl && scl_q && !sda_q && sda;
	assign rise       = scl && !scl_q;
	assign fall       = !scl && scl_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 256; i++)
				mem[i] <= {i[3:0], i[7:4]} ^ 8'h96;	// nibble swap fill
			state         <= M_IDLE;
			scl_q         <= 1'b1;
			sda_q         <= 1'b1;
			bit_cnt       <= 4'd0;
			shreg         <= 8'h00;
			out_byte      <= 8'h00;
			ptr           <= 8'h00;
			byte_n        <= 2'd0;
			to_send       <= 1'b0;
			mack          <= 1'b0;
			sda_drive_low <= 1'b0;
		end
		else
		begin
			scl_q <= scl;
			sda_q <= sda;
			if (start_seen)
			begin
				state         <= M_RECV;
				bit_cnt       <= 4'd0;
				byte_n        <= 2'd0;
				sda_drive_low <= 1'b0;
			end
			else if (stop_seen)
			begin
				state         <= M_IDLE;
				sda_drive_low <= 1'b0;
			end
			else if (rise)
			begin
				case (state)
					M_RECV:
					begin
						shreg   <= {shreg[6:0], sda};
						bit_cnt <= bit_cnt + 4'd1;
					end
					M_SEND:
					begin
						out_byte <= {out_byte[6:0], 1'b0};
						bit_cnt  <= bit_cnt + 4'd1;
					end
					M_MACK:  mack <= !sda;
					default: ;
				endcase
			end
			else if (fall)
			begin
				case (state)
					M_RECV:
						if (bit_cnt == 4'd8)
						begin
							if (byte_n != 2'd2)
								byte_n <= byte_n + 2'd1;
							if (byte_n == 2'd0 && shreg[7:1] != DEV_ID)
								state <= M_IDLE;	// not us, stay off the bus
							else
							begin
								sda_drive_low <= 1'b1;
								state         <= M_ACK;
								to_send       <= (byte_n == 2'd0) && shreg[0];
								if (byte_n == 2'd1)
									ptr <= shreg;
								else if (byte_n == 2'd2)
								begin
									mem[ptr] <= shreg;
									ptr      <= ptr + 8'd1;
								end
							end
						end
					M_ACK:
					begin
						bit_cnt <= 4'd0;
						if (to_send)
						begin
							out_byte      <= mem[ptr];
							sda_drive_low <= !mem[ptr][7];
							state         <= M_SEND;
						end
						else
						begin
							sda_drive_low <= 1'b0;
							state         <= M_RECV;
						end
					end
					M_SEND:
						if (bit_cnt == 4'd8)
						begin
							sda_drive_low <= 1'b0;	// let the master ack
							state         <= M_MACK;
						end
						else
							sda_drive_low <= !out_byte[7];
					M_MACK:
						if (mack)
						begin
							ptr           <= ptr + 8'd1;
							out_byte      <= mem[ptr + 8'd1];
							sda_drive_low <= !mem[ptr + 8'd1][7];
							bit_cnt       <= 4'd0;
							state         <= M_SEND;
						end
						else
							state <= M_IDLE;	// last byte, wait for stop
					default: ;
				endcase
			end
		end
	end

endmodule

//--- hdl/iic_eeprom_ctrl.sv
//**************************************************
// serial EEPROM controller, top level
// command is a one-cycle pulse, busy falls when the transfer ends
// SDA is split into a pull-low drive and the sensed bus level
//**************************************************
`timescale 1ns/1ps

module iic_eeprom_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [1:0]           command,	// [1] write, [0] read
	input  logic                 two_bytes,
	input  logic                 software_wp,
	input  iic_pkg::iic_dev_id_t dev_id,
	input  iic_pkg::iic_byte_t   word_addr,
	input  iic_pkg::iic_word_t   wr_data,
	output logic                 busy,
	output logic                 fail,
	output iic_pkg::iic_word_t   rd_data,
	output logic                 scl,
	output logic                 sda_drive_low,
	input  logic                 sda_in
);
	logic tick;

	iic_op_if   op_if ();
	iic_byte_if byte_if ();

	iic_tick_gen u_tick (.clk(clk), .rst_n(rst_n), .tick(tick));

	iic_cmd_ctrl u_cmd (
		.clk(clk), .rst_n(rst_n), .command(command), .two_bytes(two_bytes),
		.software_wp(software_wp), .dev_id(dev_id), .word_addr(word_addr),
		.wr_data(wr_data), .busy(busy), .fail(fail), .rd_data(rd_data),
		.op(op_if.ctrl)
	);

	iic_seq u_seq (.clk(clk), .rst_n(rst_n), .op(op_if.seq), .bus(byte_if.seq));

	iic_byte_engine u_eng (
		.clk(clk), .rst_n(rst_n), .tick(tick), .sda_in(sda_in), .scl(scl),
		.sda_drive_low(sda_drive_low), .bus(byte_if.eng)
	);

endmodule

//--- hdl/iic_byte_engine.sv
//**************************************************
// bit level bus driver
// one phase per tick: even phases pull SCL low, odd phases release it
// start and stop take 2 phases, a byte plus its ACK takes 18
// SDA leaves through one extra register so it moves after SCL falls
//**************************************************
`timescale 1ns/1ps
`include "iic_cfg.svh"

module iic_byte_engine (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    tick,
	input  logic    sda_in,
	output logic    scl,
	output logic    sda_drive_low,
	iic_byte_if.eng bus
);
	localparam int unsigned ACK_PH  = 2 * `IIC_BYTE_W;
	localparam int unsigned LAST_PH = ACK_PH + 1;
	localparam int unsigned PH_W    = $clog2(LAST_PH + 1);

	iic_pkg::iic_byte_op_e cur_op;
	iic_pkg::iic_byte_t    shreg;		// tx bits out, rx bits in
	logic [PH_W-1:0]       ph;
	logic                  active;
	logic                  is_byte;
	logic                  last_ph;
	logic                  step;
	logic                  sda_low;		// internal SDA decision
	logic                  mack;

	assign is_byte     = (cur_op == iic_pkg::OP_TX) || (cur_op == iic_pkg::OP_RX);
	assign last_ph     = is_byte ? (ph == PH_W'(LAST_PH)) : ph[0];
	assign step        = active && tick;
	assign bus.rx_byte = shreg;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active       <= 1'b0;
			cur_op       <= iic_pkg::OP_STOP;
			ph           <= '0;
			scl          <= 1'b1;
			sda_low      <= 1'b0;
			bus.done     <= 1'b0;
			bus.ack_seen <= 1'b0;
		end
		else
		begin
			bus.done <= step && last_ph;
			if (bus.req)
			begin
				active <= 1'b1;
				cur_op <= bus.op;
				ph     <= '0;
			end
			else if (step)
			begin
				ph  <= ph + 1'b1;
				scl <= ph[0];		// low then high
				if (last_ph)
					active <= 1'b0;
				case (cur_op)
					iic_pkg::OP_START: sda_low <= ph[0];	// SDA falls with SCL high
					iic_pkg::OP_STOP:  sda_low <= !ph[0];	// SDA rises with SCL high
					default:
						if (!ph[0])
						begin
							if (ph == PH_W'(ACK_PH))
								sda_low <= (cur_op == iic_pkg::OP_RX) && mack;
							else
								sda_low <= (cur_op == iic_pkg::OP_TX) && !shreg[`IIC_BYTE_W-1];
						end
						else if (ph == PH_W'(LAST_PH) && cur_op == iic_pkg::OP_TX)
							bus.ack_seen <= !sda_in;	// slave ack as SCL rises
				endcase
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (bus.req)
		begin
			shreg <= bus.tx_byte;
			mack  <= bus.master_ack;
		end
		else if (step && is_byte && ph[0] && ph < PH_W'(ACK_PH))
			shreg <= {shreg[`IIC_BYTE_W-2:0], sda_in};	// msb first
	end

	//**************************************************
	// SDA output stage
	//**************************************************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sda_drive_low <= 1'b0;
		else
			sda_drive_low <= sda_low;
	end

	a_sda_stable: assert property (@(posedge clk) disable iff (!rst_n)
		($changed(sda_drive_low) && scl) |-> cur_op inside {iic_pkg::OP_START, iic_pkg::OP_STOP})
		else $error("SDA moved while SCL high outside start/stop");

endmodule

//--- hdl/iic_seq.sv
//**************************************************
// transfer sequencer
// write: start, dev+w, word addr, data bytes, stop
// read: start, dev+w, word addr, restart, dev+r, data bytes, stop
// a missing ACK goes straight to stop and is reported as nack
//**************************************************
`timescale 1ns/1ps
`include "iic_cfg.svh"

module iic_seq (
	input  logic    clk,
	input  logic    rst_n,
	iic_op_if.seq   op,
	iic_byte_if.seq bus
);
	iic_pkg::iic_seq_state_e state;
	iic_pkg::iic_seq_state_e nxt;
	iic_pkg::iic_byte_op_e   nxt_op;
	iic_pkg::iic_byte_t      nxt_byte;
	iic_pkg::iic_word_t      rd_word;
	logic                    nack;
	logic                    is_tx;
	logic                    launch;
	logic                    inflight;

	assign is_tx  = state inside {iic_pkg::DEV_W, iic_pkg::WORD, iic_pkg::DATA_HI,
		iic_pkg::DATA_LO, iic_pkg::DEV_R};
	assign launch = (nxt != state);	// every move issues the next byte op

	assign op.done    = (state == iic_pkg::FINISH);
	assign op.nack    = nack;
	assign op.rd_data = rd_word;

	//**************************************************
	// next state
	//**************************************************
	always_comb
	begin
		nxt = state;
		case (state)
			iic_pkg::IDLE:    if (op.start) nxt = iic_pkg::START;
			iic_pkg::START:   if (bus.done) nxt = iic_pkg::DEV_W;
			iic_pkg::DEV_W:   if (bus.done) nxt = bus.ack_seen ? iic_pkg::WORD : iic_pkg::STOP;
			iic_pkg::WORD:
				if (bus.done)
				begin
					if (!bus.ack_seen)
						nxt = iic_pkg::STOP;
					else if (op.is_read)
						nxt = iic_pkg::RESTART;	// dummy write done
					else
						nxt = op.two_bytes ? iic_pkg::DATA_HI : iic_pkg::DATA_LO;
				end
			iic_pkg::DATA_HI: if (bus.done) nxt = bus.ack_seen ? iic_pkg::DATA_LO : iic_pkg::STOP;
			iic_pkg::DATA_LO: if (bus.done) nxt = iic_pkg::STOP;
			iic_pkg::RESTART: if (bus.done) nxt = iic_pkg::DEV_R;
			iic_pkg::DEV_R:
				if (bus.done)
				begin
					if (!bus.ack_seen)
						nxt = iic_pkg::STOP;
					else
						nxt = op.two_bytes ? iic_pkg::RD_HI : iic_pkg::RD_LO;
				end
			iic_pkg::RD_HI:   if (bus.done) nxt = iic_pkg::RD_LO;
			iic_pkg::RD_LO:   if (bus.done) nxt = iic_pkg::STOP;
			iic_pkg::STOP:    if (bus.done) nxt = iic_pkg::FINISH;
			default:          nxt = iic_pkg::IDLE;
		endcase
	end

	// byte op and payload for the state being entered
	always_comb
	begin
		case (nxt)
			iic_pkg::START, iic_pkg::RESTART: nxt_op = iic_pkg::OP_START;
			iic_pkg::STOP:                    nxt_op = iic_pkg::OP_STOP;
			iic_pkg::RD_HI, iic_pkg::RD_LO:   nxt_op = iic_pkg::OP_RX;
			default:                          nxt_op = iic_pkg::OP_TX;
		endcase
		case (nxt)
			iic_pkg::DEV_W:   nxt_byte = {op.dev_id, 1'b0};
			iic_pkg::WORD:    nxt_byte = op.word_addr;
			iic_pkg::DATA_HI: nxt_byte = op.wr_data[`IIC_WORD_W-1 -: `IIC_BYTE_W];
			iic_pkg::DATA_LO: nxt_byte = op.wr_data[`IIC_BYTE_W-1:0];
			iic_pkg::DEV_R:   nxt_byte = {op.dev_id, 1'b1};
			default:          nxt_byte = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= iic_pkg::IDLE;
			bus.req  <= 1'b0;
			bus.op   <= iic_pkg::OP_START;
			nack     <= 1'b0;
			inflight <= 1'b0;
		end
		else
		begin
			state   <= nxt;
			bus.req <= launch && (nxt != iic_pkg::FINISH) && (nxt != iic_pkg::IDLE);
			if (launch)
				bus.op <= nxt_op;
			if (op.start && state == iic_pkg::IDLE)
				nack <= 1'b0;
			else if (bus.done && is_tx && !bus.ack_seen)
				nack <= 1'b1;
			if (bus.req)
				inflight <= 1'b1;
			else if (bus.done)
				inflight <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			bus.tx_byte    <= nxt_byte;
			bus.master_ack <= (nxt == iic_pkg::RD_HI);	// last byte gets no ack
		end
		if (bus.done && (state == iic_pkg::RD_HI || state == iic_pkg::RD_LO))
			rd_word <= {rd_word[`IIC_BYTE_W-1:0], bus.rx_byte};	// high byte first
	end

	a_one_req: assert property (@(posedge clk) disable iff (!rst_n) bus.req |-> !inflight)
		else $error("byte request issued before previous done");

endmodule

//--- hdl/iic_cmd_ctrl.sv
//**************************************************
// command front end
// takes write/read pulses while idle, checks write protect,
// launches one transfer and reports busy, fail and read data
//**************************************************
`timescale 1ns/1ps
`include "iic_cfg.svh"

module iic_cmd_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [1:0]           command,	// [1] write, [0] read
	input  logic                 two_bytes,
	input  logic                 software_wp,
	input  iic_pkg::iic_dev_id_t dev_id,
	input  iic_pkg::iic_byte_t   word_addr,
	input  iic_pkg::iic_word_t   wr_data,
	output logic                 busy,
	output logic                 fail,
	output iic_pkg::iic_word_t   rd_data,
	iic_op_if.ctrl               op
);
	logic reject;	// protected write seen last cycle
	logic idle;
	logic accept;

	assign idle   = !busy && !reject;
	assign accept = idle && (command != 2'b00) && !(command[1] && software_wp);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy     <= 1'b0;
			fail     <= 1'b0;
			reject   <= 1'b0;
			op.start <= 1'b0;
			rd_data  <= '0;
		end
		else
		begin
			op.start <= accept;
			reject   <= idle && command[1] && software_wp;
			if (accept)
			begin
				busy <= 1'b1;
				fail <= 1'b0;
			end
			if (reject)
				fail <= 1'b1;
			if (op.done)
			begin
				busy <= 1'b0;
				fail <= op.nack;
				if (op.is_read && !op.nack)
					rd_data <= op.two_bytes ? op.rd_data :
						{{(`IIC_WORD_W-`IIC_BYTE_W){1'b0}}, op.rd_data[`IIC_BYTE_W-1:0]};
			end
		end
	end

	// operands held steady for the whole transfer
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op.is_read   <= !command[1];	// write wins if both set
			op.two_bytes <= two_bytes;
			op.dev_id    <= dev_id;
			op.word_addr <= word_addr;
			op.wr_data   <= wr_data;
		end
	end

	a_done_busy: assert property (@(posedge clk) disable iff (!rst_n) op.done |-> busy)
		else $error("transfer finished with no transfer open");

endmodule

//--- hdl/iic_tick_gen.sv
//**************************************************
// bus phase timebase
// one-cycle tick every IIC_TICK_DIV clocks
//**************************************************
`timescale 1ns/1ps
`include "iic_cfg.svh"

module iic_tick_gen (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);
	localparam int unsigned CNT_W = $clog2(`IIC_TICK_DIV);

	logic [CNT_W-1:0] cnt;
	logic             wrap;

	assign wrap = (cnt == CNT_W'(`IIC_TICK_DIV - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tick <= wrap;
			cnt  <= wrap ? '0 : cnt + 1'b1;	// free running
		end
	end

	a_tick_single: assert property (@(posedge clk) disable iff (!rst_n) tick |=> !tick)
		else $error("tick held for more than one cycle");

endmodule

//--- hdl/iic_if.sv
//**************************************************
// internal links of the serial EEPROM controller
// iic_op_if carries one whole transfer, command side to sequencer
// iic_byte_if carries one bus phase request, sequencer to byte engine
//**************************************************
`timescale 1ns/1ps

interface iic_op_if;
	logic                 start;		// one-cycle pulse
	logic                 is_read;
	logic                 two_bytes;
	iic_pkg::iic_dev_id_t dev_id;
	iic_pkg::iic_byte_t   word_addr;
	iic_pkg::iic_word_t   wr_data;
	logic                 done;		// one-cycle pulse
	logic                 nack;		// valid with done
	iic_pkg::iic_word_t   rd_data;	// valid with done

	modport ctrl (output start, is_read, two_bytes, dev_id, word_addr, wr_data,
		input done, nack, rd_data);
	modport seq (input start, is_read, two_bytes, dev_id, word_addr, wr_data,
		output done, nack, rd_data);
endinterface

interface iic_byte_if;
	logic                   req;		// one-cycle pulse
	iic_pkg::iic_byte_op_e  op;
	iic_pkg::iic_byte_t     tx_byte;
	logic                   master_ack;	// OP_RX only
	logic                   done;		// one-cycle pulse
	iic_pkg::iic_byte_t     rx_byte;
	logic                   ack_seen;	// slave pulled SDA low on OP_TX

	modport seq (output req, op, tx_byte, master_ack,
		input done, rx_byte, ack_seen);
	modport eng (input req, op, tx_byte, master_ack,
		output done, rx_byte, ack_seen);
endinterface

//--- hdl/iic_pkg.sv
//**************************************************
// shared types of the serial EEPROM controller
// referenced by scoped name from the RTL files
//**************************************************
`include "iic_cfg.svh"

package iic_pkg;

	typedef logic [`IIC_BYTE_W-1:0] iic_byte_t;
	typedef logic [`IIC_WORD_W-1:0] iic_word_t;
	typedef logic [6:0]             iic_dev_id_t;	// 7-bit slave address

	// what the byte engine does for one request
	typedef enum logic [1:0] {OP_START, OP_STOP, OP_TX, OP_RX} iic_byte_op_e;

	// transfer sequencer
	typedef enum logic [3:0] {
		IDLE, START, DEV_W, WORD, DATA_HI, DATA_LO,
		RESTART, DEV_R, RD_HI, RD_LO, STOP, FINISH
	} iic_seq_state_e;

endpackage

//--- hdl/iic_cfg.svh
//**************************************************
// build-time constants for the serial EEPROM controller
// include wherever a width or the tick divider is needed
//**************************************************
`ifndef IIC_CFG_SVH
`define IIC_CFG_SVH

// clk cycles per SCL phase, kept short for simulation
`define IIC_TICK_DIV 8

// one bus byte
`define IIC_BYTE_W 8

// data word, high byte goes first on the bus
`define IIC_WORD_W 16
`endif
